//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := bitScanTb
FILELIST  := src.f
BUILD     := obj_dir
SIM       := $(BUILD)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS      := Testbench passed

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(BUILD)

//--- bench/bitScanTb.sv
`timescale 1ns/100ps

module bitScanTb;

	import bitScanPkg::*;

	localparam int width = 32;
	localparam int speed = 1;
	localparam int cntW = cntWidth(width);
	localparam int numRandom = 3000; // random ops after the directed ones
	localparam int drainLimit = 20;  // cycles allowed for the pipe to empty

	// one expected result, pushed when the op is accepted
	typedef struct packed {
		scanOpE           op;
		logic [cntW-1:0]  count;
		logic [width-1:0] data;
		logic             allSame;
	} scoreT;

	logic             clk = 1'b0;
	logic             rstN;
	logic             inValid;
	scanOpE           inOp;
	logic [width-1:0] inData;
	logic             outValid;
	logic [cntW-1:0]  outCount;
	logic [width-1:0] outData;
	logic             outAllSame;

	scoreT       expQ[$];           // scoreboard, oldest first
	logic [2:0]  validHist = '0;    // accepted flags of the last three cycles
	logic [31:0] rngState;
	int          resultCount = 0;

	bitScanTop #(
		.width(width),
		.speed(speed)
	) i_dut (
		.clk       (clk),
		.rstN      (rstN),
		.inValid   (inValid),
		.inOp      (inOp),
		.inData    (inData),
		.outValid  (outValid),
		.outCount  (outCount),
		.outData   (outData),
		.outAllSame(outAllSame)
	);

	initial begin
		forever #4 clk = ~clk; // 8 ns period
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic nextRandom(output logic [31:0] r);
		rngState = xorshift(rngState);
		r = rngState;
	endtask

	// run of bits equal to refBit, counted from the msb
	function automatic logic [cntW-1:0] leadCount(input logic [width-1:0] value,
			input logic refBit);
		int   n;
		logic stillRun;
		n = 0;
		stillRun = 1'b1;
		for (int i = width - 1; i >= 0; i--) begin
			if (stillRun && value[i] == refBit) begin
				n++;
			end else begin
				stillRun = 1'b0; // first differing bit ends the run
			end
		end
		return cntW'(n);
	endfunction

	function automatic scoreT modelOp(input scanOpE op, input logic [width-1:0] value);
		scoreT            e;
		logic             refBit;
		logic [width-1:0] normData;
		case (op)
			opClo:   refBit = 1'b1;
			opCls:   refBit = value[width-1]; // sign bit counts itself
			default: refBit = 1'b0;           // clz and norm
		endcase
		// one place at a time until the msb is set
		normData = value;
		for (int i = 0; i < width && !normData[width-1]; i++) begin
			normData = normData << 1;
		end
		e.op      = op;
		e.count   = leadCount(value, refBit);
		e.data    = (op == opNorm) ? normData : value;
		e.allSame = (value == {width{refBit}}); // every bit matches the reference
		return e;
	endfunction

	function automatic string opLabel(input scanOpE op);
		case (op)
			opClo:   return "clo";
			opClz:   return "clz";
			opCls:   return "cls";
			default: return "norm";
		endcase
	endfunction

	function automatic logic [width-1:0] edgeOperand(input int idx);
		case (idx)
			0:       return {width{1'b1}};
			1:       return '0;
			2:       return {1'b1, {(width-1){1'b0}}}; // msb only
			3:       return {1'b0, {(width-1){1'b1}}}; // largest positive
			4:       return width'(1);
			default: return {2'b10, {(width-2){1'b1}}};
		endcase
	endfunction

	// mostly long runs of ones or zeros from the msb down
	task automatic randomOperand(output logic [width-1:0] value);
		logic [31:0]      r1;
		logic [31:0]      r2;
		logic [width-1:0] mask;
		int               k;
		nextRandom(r1);
		nextRandom(r2);
		k = r2 % 33;
		mask = ~({width{1'b1}} >> k); // top k bits set
		value = width'(r1);
		case (r2[8:6])
			3'd0:             value = width'(r1);
			3'd1, 3'd2, 3'd3: value = value | mask;
			3'd4, 3'd5, 3'd6: value = value & ~mask;
			default:          value = edgeOperand(int'(r2[11:9]) % 6);
		endcase
	endtask

	task automatic driveOp(input logic valid, input scanOpE op, input logic [width-1:0] value);
		@(posedge clk);
		inValid <= valid;
		inOp    <= op;
		inData  <= value;
	endtask

	task automatic stopOnFailure();
		$display("Testbench failed");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic compareValue(input string testName, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("Error: %s expected 0x%0h actual 0x%0h", testName, expected, actual);
			stopOnFailure();
		end
	endtask

	// inputs and outputs are both settled at the falling edge
	always @(negedge clk) begin
		scoreT want;
		string tag;
		logic  accepted;
		accepted = (inValid === 1'b1) && (rstN === 1'b1);
		if (rstN === 1'b1) begin
			compareValue("outValid latency", 64'(validHist[2]), 64'(outValid));
			if (outValid) begin
				if (expQ.size() == 0) begin
					$display("outValid went high with no operation left to check");
					stopOnFailure();
				end else begin
					want = expQ.pop_front();
					tag = opLabel(want.op);
					compareValue({tag, " count"}, 64'(want.count), 64'(outCount));
					compareValue({tag, " data"}, 64'(want.data), 64'(outData));
					compareValue({tag, " allSame"}, 64'(want.allSame), 64'(outAllSame));
					resultCount++;
				end
			end
		end
		if (accepted) begin
			expQ.push_back(modelOp(inOp, inData)); // dut takes it at the next rise
		end
		validHist = {validHist[1:0], accepted};
	end

	initial begin
		logic [31:0]      r;
		logic [width-1:0] value;
		int               drainCycles;
		rngState = 32'h6f8a;
		rstN     = 1'b0;
		inValid  = 1'b0;
		inOp     = opClo;
		inData   = '0;
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		repeat (3) driveOp(1'b0, opClo, '0); // quiet pipe right after reset

		// every edge operand through every op, back to back
		for (int e = 0; e < 6; e++) begin
			for (int o = 0; o < 4; o++) begin
				driveOp(1'b1, scanOpE'(2'(o)), edgeOperand(e));
			end
		end

		repeat (numRandom) begin
			nextRandom(r);
			randomOperand(value);
			driveOp(r[1:0] != 2'b00, scanOpE'(r[3:2]), value); // about 3 in 4 valid
		end
		driveOp(1'b0, opClo, '0);

		drainCycles = 0;
		while (expQ.size() != 0 && drainCycles < drainLimit) begin
			@(posedge clk);
			drainCycles++;
		end
		if (expQ.size() != 0) begin
			$display("timed out with %0d results still missing from the DUT", expQ.size());
			stopOnFailure();
		end
		repeat (4) @(posedge clk); // outValid must stay low while idle

		if (resultCount == 0) begin
			$display("no results came out of the DUT to check");
			stopOnFailure();
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

//--- src.f
src/bitScanPkg.sv
src/PrefixAnd.sv
src/LeadOneDet.sv
src/scanDecode.sv
src/scanExecute.sv
src/scanResult.sv
src/bitScanTop.sv
bench/bitScanTb.sv

//--- src/LeadOneDet.sv
`timescale 1ns/100ps

module LeadOneDet #(
	parameter int width = 8, // operand width
	parameter int speed = 1  // prefix variant
) (
	input  logic [width-1:0] A, // operand
	output logic [width-1:0] Z  // marks first zero below msb run
);

	logic [width-1:0] rev;    // msb moved to bit 0
	logic [width-1:0] revAnd; // prefix and of rev
	logic [width-1:0] run;    // run[i] high while A[width-1:i] all ones

	for (genvar i = 0; i < width; i++) begin : flipIn
		assign rev[i] = A[width-1-i];
	end

	// prefix runs from msb downwards after the flip
	PrefixAnd #(
		.width(width),
		.speed(speed)
	) i_prefixAnd (
		.PI(rev),
		.PO(revAnd)
	);

	for (genvar i = 0; i < width; i++) begin : flipOut
		assign run[i] = revAnd[width-1-i];
	end

	// a zero bit whose upper neighbours are all ones
	assign Z[width-1]   = ~A[width-1];
	assign Z[width-2:0] = run[width-1:1] & ~A[width-2:0]; // all ones gives zero
	// e.g. 111010 -> 000100

endmodule

//--- src/PrefixAnd.sv
`timescale 1ns/100ps

module PrefixAnd #(
	parameter int width = 8, // word width
	parameter int speed = 1  // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] PI, // propagate in
	output logic [width-1:0] PO  // PO[i] = &PI[i:0]
);

	localparam int m = $clog2(width); // tree depth

	if (speed == 2) begin : fastPrefix
		// sklansky, m levels, high fanout at the group tops
		logic [width-1:0] lvl;

		always_comb begin
			lvl = PI;
			for (int l = 1; l <= m; l++) begin
				for (int i = 0; i < width; i++) begin
					// upper half of each 2^l group takes the lower half's top bit
					if ((i % (1 << l)) >= (1 << (l - 1))) begin
						lvl[i] = lvl[i] & lvl[((i >> l) << l) + (1 << (l - 1)) - 1];
					end
				end
			end
			PO = lvl;
		end
	end else if (speed == 1) begin : mediumPrefix
		// brent-kung, 2m-1 levels, fanout of two
		logic [width-1:0] lvl;

		always_comb begin
			lvl = PI;
			// up sweep builds block tops at 2^l-1
			for (int l = 1; l <= m; l++) begin
				for (int i = 0; i < width; i++) begin
					if (((i + 1) % (1 << l)) == 0) begin
						lvl[i] = lvl[i] & lvl[i - (1 << (l - 1))];
					end
				end
			end
			// down sweep fills in the midpoints
			for (int l = m - 1; l >= 1; l--) begin
				for (int i = 1 << l; i < width; i++) begin
					if (((i + 1) % (1 << l)) == (1 << (l - 1))) begin
						lvl[i] = lvl[i] & lvl[i - (1 << (l - 1))]; // source is a finished top
					end
				end
			end
			PO = lvl;
		end
	end else begin : slowPrefix
		// ripple chain, width-1 gates deep
		logic [width-1:0] chain;

		always_comb begin
			chain = PI;
			for (int i = 1; i < width; i++) begin
				chain[i] = chain[i] & chain[i-1];
			end
			PO = chain;
		end
	end

endmodule

//--- src/bitScanPkg.sv
package bitScanPkg;

	// operation select, two bits on the input port
	typedef enum logic [1:0] {
		opClo  = 2'd0, // count leading ones
		opClz  = 2'd1, // count leading zeros
		opCls  = 2'd2, // count leading sign bits
		opNorm = 2'd3  // normalize by leading zeros
	} scanOpE;

	// control word that rides along with each operand
	typedef struct packed {
		logic valid;   // real op in this stage
		logic invert;  // complement before detect
		logic signSel; // complement only if msb clear
		logic norm;    // shift left by count
	} scanCtrlT;

	// floor(log2(n)), -1 for n below one
	function automatic int log2Floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		while (p <= n) begin
			m++;
			p = p * 2;
		end
		return m;
	endfunction

	// bits needed for counts 0..width, width itself included
	function automatic int cntWidth(input int width);
		return log2Floor(width) + 1;
	endfunction

endpackage

//--- src/bitScanTop.sv
`timescale 1ns/100ps

module bitScanTop #(
	parameter int width = 32, // operand width
	parameter int speed = 1   // prefix variant, 0..2
) (
	input  logic                                   clk,
	input  logic                                   rstN,
	input  logic                                   inValid,
	input  bitScanPkg::scanOpE                     inOp,
	input  logic [width-1:0]                       inData,
	output logic                                   outValid,
	output logic [bitScanPkg::cntWidth(width)-1:0] outCount,
	output logic [width-1:0]                       outData,
	output logic                                   outAllSame
);

	import bitScanPkg::*;

	scanCtrlT                   decCtrl;  // decode -> execute
	logic [width-1:0]           decData;
	scanCtrlT                   exeCtrl;  // execute -> result
	logic [width-1:0]           exeData;
	logic [cntWidth(width)-1:0] exeCount;

	scanDecode #(
		.width(width)
	) i_decode (
		.clk    (clk),
		.rstN   (rstN),
		.inValid(inValid),
		.inOp   (inOp),
		.inData (inData),
		.ctrl   (decCtrl),
		.data   (decData)
	);

	scanExecute #(
		.width(width),
		.speed(speed)
	) i_execute (
		.clk    (clk),
		.rstN   (rstN),
		.ctrlIn (decCtrl),
		.dataIn (decData),
		.ctrlOut(exeCtrl),
		.dataOut(exeData),
		.count  (exeCount)
	);

	scanResult #(
		.width(width)
	) i_result (
		.clk       (clk),
		.rstN      (rstN),
		.ctrl      (exeCtrl),
		.data      (exeData),
		.count     (exeCount),
		.outValid  (outValid),
		.outCount  (outCount),
		.outData   (outData),
		.outAllSame(outAllSame)
	);

endmodule

//--- src/scanDecode.sv
`timescale 1ns/100ps

module scanDecode #(
	parameter int width = 32
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 inValid, // op strobe
	input  bitScanPkg::scanOpE   inOp,
	input  logic [width-1:0]     inData,
	output bitScanPkg::scanCtrlT ctrl,
	output logic [width-1:0]     data
);

	import bitScanPkg::*;

	scanCtrlT dec; // next control word

	always_comb begin
		dec = '0;
		dec.valid = inValid;
		unique case (inOp)
			opClo:  dec.invert = 1'b0; // ones counted as is
			opClz:  dec.invert = 1'b1;
			opCls:  dec.signSel = 1'b1; // flip follows the msb
			opNorm: begin
				dec.invert = 1'b1; // zeros to shift out
				dec.norm   = 1'b1;
			end
			default: dec = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrl <= '0;
		end else begin
			ctrl <= dec;
		end
	end

	always_ff @(posedge clk) begin
		data <= inData; // payload, don't care when not valid
	end

	// opcode must be known whenever it is strobed in
	assert property (@(posedge clk) disable iff (!rstN) inValid |-> !$isunknown(inOp));

endmodule

//--- src/scanExecute.sv
`timescale 1ns/100ps

module scanExecute #(
	parameter int width = 32,
	parameter int speed = 1
) (
	input  logic                                     clk,
	input  logic                                     rstN,
	input  bitScanPkg::scanCtrlT                     ctrlIn,
	input  logic [width-1:0]                         dataIn,
	output bitScanPkg::scanCtrlT                     ctrlOut,
	output logic [width-1:0]                         dataOut,
	output logic [bitScanPkg::cntWidth(width)-1:0]   count
);

	import bitScanPkg::*;

	localparam int cntW = cntWidth(width);

	logic             flip;   // complement operand
	logic [width-1:0] cond;   // counted bits are ones here
	logic [width-1:0] marker; // one-hot first zero
	logic [cntW-1:0]  cnt;    // encoded run length

	// cls flips negative-free operands so the sign run is ones
	assign flip = ctrlIn.invert | (ctrlIn.signSel & ~dataIn[width-1]);
	assign cond = dataIn ^ {width{flip}};

	LeadOneDet #(
		.width(width),
		.speed(speed)
	) i_leadOneDet (
		.A(cond),
		.Z(marker)
	);

	// marker at bit i means width-1-i ones above it
	always_comb begin
		cnt = cntW'(width); // no marker, whole word matches
		for (int i = 0; i < width; i++) begin
			if (marker[i]) begin
				cnt = cntW'(width - 1 - i);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrlOut <= '0;
		end else begin
			ctrlOut <= ctrlIn;
		end
	end

	always_ff @(posedge clk) begin
		dataOut <= dataIn; // original operand, not cond
		count   <= cnt;
	end

	// encoder relies on at most one marker bit
	assert property (@(posedge clk) disable iff (!rstN) ctrlIn.valid |-> $onehot0(marker));

endmodule

//--- src/scanResult.sv
`timescale 1ns/100ps

module scanResult #(
	parameter int width = 32
) (
	input  logic                                   clk,
	input  logic                                   rstN,
	input  bitScanPkg::scanCtrlT                   ctrl,
	input  logic [width-1:0]                       data,
	input  logic [bitScanPkg::cntWidth(width)-1:0] count,
	output logic                                   outValid,
	output logic [bitScanPkg::cntWidth(width)-1:0] outCount,
	output logic [width-1:0]                       outData,
	output logic                                   outAllSame
);

	import bitScanPkg::*;

	localparam int cntW = cntWidth(width);

	logic [width-1:0] shifted; // normalized or passthrough
	logic             allSame; // whole word counted

	assign shifted = ctrl.norm ? (data << count) : data; // zero fill from lsb
	assign allSame = (count == cntW'(width));

	always_ff @(posedge clk) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else begin
			outValid <= ctrl.valid;
		end
	end

	always_ff @(posedge clk) begin
		outCount   <= count;
		outData    <= shifted;
		outAllSame <= allSame;
	end

	// count from execute never runs past the word
	assert property (@(posedge clk) disable iff (!rstN) outValid |-> outCount <= cntW'(width));

endmodule
